/* ddr3_wr_control.f */
source/ddr3_wr_pkg.sv
source/wr_sequencer.sv
source/wr_burst_counters.sv
source/wr_address_gen.sv
source/fill_header_builder.sv
source/ddr3_wr_control.sv
testbench/ddr3_wr_control_props.sv
testbench/tb_ddr3_wr_control.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the ddr3 write controller testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ddr3_wr_control \
  --Mdir obj_dir -o sim_ddr3_wr_control \
  -f ddr3_wr_control.f
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit $status
fi

./obj_dir/sim_ddr3_wr_control
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0

/* source/ddr3_wr_control.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr3_wr_control import ddr3_wr_pkg::*; #(
  parameter int CREDIT_WIDTH = 5,  // address throttle width
  parameter int SYNC_STAGES  = 2   // acq_done synchroniser depth
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        acq_enabled,
  input  logic        acq_done,
  input  logic        checksum_memory_range,
  input  fifo_word_t  fifo_word,     // fwft head of the adc fifo
  input  logic        fifo_empty,
  output logic        fifo_rd_en,
  output logic        app_wdf_wren,
  output logic        app_wdf_end,
  input  logic        app_wdf_rdy,
  output ddr3_addr_t  wr_addr,
  output logic        wr_app_en,
  input  logic        wr_app_rdy,
  output header_rec_t header_wr_dat,
  output logic        header_wr_en,
  output logic        sync_err,
  output logic        wr_done
);

  wr_cmd_t cmd;
  logic    window;
  logic    addr_accept;
  logic    xfer_done;

  wr_sequencer #(.SYNC_STAGES(SYNC_STAGES)) u_wr_sequencer (
    .clk, .reset, .acq_enabled, .acq_done, .fifo_empty, .xfer_done,
    .tag(fifo_word.tag),
    .cmd, .window, .header_wr_en, .sync_err, .wr_done
  );

  wr_burst_counters #(.CREDIT_WIDTH(CREDIT_WIDTH)) u_wr_burst_counters (
    .clk, .reset, .window, .fifo_empty, .app_wdf_rdy, .wr_app_rdy, .cmd,
    .header_burst_cnt(fifo_word.payload[BURST_CNT_BITS-1:0]),  // burst count field
    .app_wdf_wren, .app_wdf_end, .wr_app_en, .fifo_rd_en, .addr_accept, .xfer_done
  );

  wr_address_gen u_wr_address_gen (
    .clk, .reset, .acq_enabled, .addr_accept, .checksum_memory_range, .cmd,
    .word(fifo_word),
    .wr_addr
  );

  fill_header_builder u_fill_header_builder (
    .clk, .reset, .addr_accept, .cmd,
    .payload(fifo_word.payload),
    .header_wr_dat
  );

endmodule

`default_nettype wire

/* source/ddr3_wr_pkg.sv */
`default_nettype none

package ddr3_wr_pkg;

  // tag values found in the top nibble of every fifo word
  typedef enum logic [3:0] {
    tag_fill = 4'd1,  // fill header, written last in a fill
    tag_wfm  = 4'd2,  // waveform header, followed by its data bursts
    tag_cksm = 4'd4   // checksum word, always a single burst
  } tag_t;

  typedef logic [127:0] payload_t;     // one burst of data, tag stripped
  typedef logic [22:0]  burst_addr_t;  // burst address, msb picks the buffer half
  typedef logic [25:0]  ddr3_addr_t;   // byte address seen by the memory controller
  typedef logic [23:0]  burst_count_t;

  typedef struct packed {
    tag_t     tag;      // [131:128]
    payload_t payload;  // [127:0]
  } fifo_word_t;

  // record pushed to the fill-header fifo
  typedef struct packed {
    burst_count_t total_bursts;  // [151:128]
    payload_t     payload;       // copy of the fill header payload
  } header_rec_t;

  // one-cycle strobes from the sequencer to the datapath blocks
  typedef struct packed {
    logic new_fill;           // restart the per-fill burst total
    logic load_header;        // latch the header record
    logic load_addr;          // take the start address from the header
    logic count_from_header;  // counters <= header burst count + 1
    logic count_one;          // counters <= 1
    logic fix_cksm_addr;      // swap in the checksum buffer bit
  } wr_cmd_t;

  typedef enum logic [3:0] {
    idle, init_all, wait_word, test_tag, sync_err,
    init_fill, write_fill, init_wfm, write_wfm,
    init_cksm, write_cksm, write_hdr, done
  } wr_state_t;

  // payload field positions
  localparam int FILL_BUF_BIT   = 24;  // buffer select in a fill header
  localparam int WFM_ADDR_LSB   = 26;  // start address lsb in a waveform header
  localparam int BURST_CNT_BITS = 14;  // burst count sits at payload[13:0]

endpackage

`default_nettype wire

/* source/fill_header_builder.sv */
`timescale 1ns/1ps
`default_nettype none

module fill_header_builder import ddr3_wr_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        addr_accept,
  input  wr_cmd_t     cmd,
  input  payload_t    payload,        // fifo head payload
  output header_rec_t header_wr_dat
);

  burst_count_t total_bursts;  // fill header + waveform bursts + checksum

  // starts at one so the fill header slot is counted up front
  always_ff @(posedge clk) begin
    if (reset) begin
      total_bursts <= '0;
    end else if (cmd.new_fill) begin
      total_bursts <= burst_count_t'(1);
    end else if (addr_accept) begin
      total_bursts <= total_bursts + 1'b1;
    end
  end

  // snapshot while the fill header is still at the fifo head
  always_ff @(posedge clk) begin
    if (cmd.load_header) begin
      header_wr_dat.total_bursts <= total_bursts;
      header_wr_dat.payload      <= payload;  // tag bits dropped
    end
  end

endmodule

`default_nettype wire

/* source/wr_address_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module wr_address_gen import ddr3_wr_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       acq_enabled,
  input  logic       addr_accept,
  input  logic       checksum_memory_range,  // buffer half that receives the checksum
  input  wr_cmd_t    cmd,
  input  fifo_word_t word,                   // fifo head, holds the header on load_addr
  output ddr3_addr_t wr_addr
);

  localparam int AW = $bits(burst_addr_t);

  burst_addr_t burst_addr;
  logic        hdr_is_fill;
  logic        hdr_is_wfm;

  assign hdr_is_fill = (word.tag == tag_fill);
  assign hdr_is_wfm  = (word.tag == tag_wfm);

  always_ff @(posedge clk) begin
    if (reset || !acq_enabled) begin
      // a fill with no waveforms still puts its checksum after the fill header slot
      burst_addr <= burst_addr_t'(1);
    end else if (cmd.load_addr && hdr_is_fill) begin
      // fill header goes to the base of its buffer half
      burst_addr <= {word.payload[FILL_BUF_BIT], {(AW-1){1'b0}}};
    end else if (cmd.load_addr && hdr_is_wfm) begin
      burst_addr <= word.payload[WFM_ADDR_LSB +: AW];  // start address from the header
    end else if (cmd.fix_cksm_addr) begin
      burst_addr <= {checksum_memory_range, burst_addr[AW-2:0]};
    end else if (addr_accept) begin
      burst_addr <= burst_addr + 1'b1;  // next burst slot
    end
  end

  assign wr_addr = {burst_addr, 3'b000};  // 8 byte lanes per burst address

endmodule

`default_nettype wire

/* source/wr_burst_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module wr_burst_counters import ddr3_wr_pkg::*; #(
  parameter int CREDIT_WIDTH = 5  // data may lead addresses by 2**CREDIT_WIDTH-1
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      window,
  input  logic                      fifo_empty,
  input  logic                      app_wdf_rdy,
  input  logic                      wr_app_rdy,
  input  wr_cmd_t                   cmd,
  input  logic [BURST_CNT_BITS-1:0] header_burst_cnt,
  output logic                      app_wdf_wren,
  output logic                      app_wdf_end,
  output logic                      wr_app_en,
  output logic                      fifo_rd_en,
  output logic                      addr_accept,
  output logic                      xfer_done
);

  localparam int ADDR_IDX = 0;  // counts accepted addresses
  localparam int DATA_IDX = 1;  // counts accepted data bursts

  burst_count_t            cnt [2];
  burst_count_t            load_val;
  logic [1:0]              cnt_step;
  logic [1:0]              cnt_zero;
  logic                    data_accept;
  logic [CREDIT_WIDTH-1:0] credit;       // data accepts not yet matched by an address
  logic                    credit_zero;
  logic                    credit_full;

  assign data_accept = app_wdf_wren & app_wdf_rdy;
  assign addr_accept = wr_app_en & wr_app_rdy;

  assign cnt_step[ADDR_IDX] = addr_accept;
  assign cnt_step[DATA_IDX] = data_accept;

  // waveform block is the header burst plus its data bursts
  assign load_val = cmd.count_one ? burst_count_t'(1)
                                  : burst_count_t'(header_burst_cnt) + 1'b1;

  // both counters load together and count down on their own accepts
  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (reset)                                      cnt[i] <= '0;
      else if (cmd.count_one || cmd.count_from_header) cnt[i] <= load_val;
      else if (cnt_step[i])                           cnt[i] <= cnt[i] - 1'b1;
    end
  end

  assign cnt_zero[ADDR_IDX] = (cnt[ADDR_IDX] == '0);
  assign cnt_zero[DATA_IDX] = (cnt[DATA_IDX] == '0);
  assign xfer_done = &cnt_zero;

  // address throttle, an address only goes out for data already taken
  always_ff @(posedge clk) begin
    if (reset) begin
      credit <= '0;
    end else if (data_accept && !addr_accept) begin
      credit <= credit + 1'b1;
    end else if (addr_accept && !data_accept) begin
      credit <= credit - 1'b1;
    end
  end

  assign credit_zero = (credit == '0);
  assign credit_full = &credit;  // stop data before the credit wraps

  assign wr_app_en    = window && !credit_zero && !cnt_zero[ADDR_IDX];
  assign app_wdf_wren = window && !fifo_empty && !cnt_zero[DATA_IDX] && !credit_full;
  assign app_wdf_end  = app_wdf_wren;  // single beat bursts
  assign fifo_rd_en   = data_accept;   // pop the head once memory has it

endmodule

`default_nettype wire

/* source/wr_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module wr_sequencer import ddr3_wr_pkg::*; #(
  parameter int SYNC_STAGES = 2  // depth of the acq_done synchroniser
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    acq_enabled,   // low holds the machine in idle
  input  logic    acq_done,      // from the acquisition side, asynchronous
  input  logic    fifo_empty,
  input  logic    xfer_done,     // both burst counters at zero
  input  tag_t    tag,           // tag of the fifo head word
  output wr_cmd_t cmd,
  output logic    window,        // write states, memory enables allowed
  output logic    header_wr_en,
  output logic    sync_err,
  output logic    wr_done
);

  logic [SYNC_STAGES-1:0] acq_done_sync;  // bit 0 samples the raw input
  logic                   acq_done_seen;
  wr_state_t              state;
  wr_state_t              next;

  // acq_done crosses from the adc side
  always_ff @(posedge clk) begin
    if (reset) begin
      acq_done_sync <= '0;
    end else begin
      acq_done_sync[0] <= acq_done;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        acq_done_sync[i] <= acq_done_sync[i-1];
      end
    end
  end

  assign acq_done_seen = acq_done_sync[SYNC_STAGES-1];

  always_ff @(posedge clk) begin
    if (reset) state <= idle;
    else       state <= next;
  end

  always_comb begin
    next = state;
    if (!acq_enabled) begin
      next = idle;  // soft reset while acquisition is off
    end else begin
      case (state)
        idle:      next = init_all;
        init_all:  next = wait_word;
        wait_word: if (!fifo_empty) next = test_tag;  // fwft, head word is valid
        test_tag: begin
          case (tag)
            tag_fill: next = init_fill;
            tag_wfm:  next = init_wfm;
            tag_cksm: next = init_cksm;
            default:  next = ddr3_wr_pkg::sync_err;  // lost framing
          endcase
        end
        ddr3_wr_pkg::sync_err: next = ddr3_wr_pkg::sync_err;  // only acq_enabled gets out
        init_fill:  next = write_fill;
        write_fill: if (xfer_done) next = write_hdr;  // header burst is in memory
        init_wfm:   next = write_wfm;
        write_wfm:  if (xfer_done) next = wait_word;
        init_cksm:  next = write_cksm;
        write_cksm: if (xfer_done) next = wait_word;
        write_hdr:  next = done;
        done:       if (acq_done_seen) next = wait_word;
        default:    next = idle;
      endcase
    end
  end

  // strobes and status come from next, so each lines up with its state
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd          <= '0;
      window       <= 1'b0;
      header_wr_en <= 1'b0;
      sync_err     <= 1'b0;
      wr_done      <= 1'b0;
    end else begin
      cmd.new_fill          <= (next == init_all);
      cmd.load_header       <= (next == init_fill);   // fill header sits at the fifo head
      cmd.load_addr         <= (next == init_fill) || (next == init_wfm);
      cmd.count_from_header <= (next == init_wfm);    // header burst + its data
      cmd.count_one         <= (next == init_fill) || (next == init_cksm);
      cmd.fix_cksm_addr     <= (next == init_cksm);   // no address load for checksum
      window       <= (next == write_fill) || (next == write_wfm) || (next == write_cksm);
      header_wr_en <= (next == write_hdr);            // single cycle, no back-pressure
      sync_err     <= (next == ddr3_wr_pkg::sync_err);
      wr_done      <= (next == done);
    end
  end

endmodule

`default_nettype wire

/* testbench/ddr3_wr_control_props.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr3_wr_control_props import ddr3_wr_pkg::*; (
  input logic       clk,
  input logic       reset,
  input logic       acq_enabled,
  input fifo_word_t fifo_word,
  input logic       fifo_rd_en,
  input logic       app_wdf_wren,
  input logic       app_wdf_end,
  input logic       app_wdf_rdy,
  input ddr3_addr_t wr_addr,
  input logic       wr_app_en,
  input logic       wr_app_rdy,
  input logic       header_wr_en,
  input logic       sync_err,
  input logic       wr_done
);

  logic [15:0] lead;  // data accepts minus address accepts

  always_ff @(posedge clk) begin
    if (reset) lead <= '0;
    else lead <= lead + 16'(app_wdf_wren & app_wdf_rdy) - 16'(wr_app_en & wr_app_rdy);
  end

  a_reset_quiet: assert property (@(posedge clk)
    reset |=> !(header_wr_en | sync_err | wr_done | wr_app_en | app_wdf_wren | fifo_rd_en))
    else $error("outputs active after reset");

  a_pop_on_accept: assert property (@(posedge clk) disable iff (reset)
    (fifo_rd_en == (app_wdf_wren && app_wdf_rdy)) && (app_wdf_end == app_wdf_wren))
    else $error("fifo pop or wdf_end does not follow data accept");

  a_data_stall: assert property (@(posedge clk) disable iff (reset)
    app_wdf_wren && !app_wdf_rdy |=> app_wdf_wren && $stable(fifo_word))
    else $error("write data changed while stalled");

  a_addr_stall: assert property (@(posedge clk) disable iff (reset)
    wr_app_en && !wr_app_rdy |=> wr_app_en && $stable(wr_addr))
    else $error("address changed while stalled");

  a_throttle: assert property (@(posedge clk) disable iff (reset)
    wr_app_en |-> lead != 0)  // address only for data already taken
    else $error("address offered ahead of data");

  a_header_pulse: assert property (@(posedge clk) disable iff (reset)
    header_wr_en |=> !header_wr_en && wr_done)
    else $error("header push not a single pulse followed by done");

  a_sync_sticky: assert property (@(posedge clk) disable iff (reset)
    sync_err && acq_enabled |=> sync_err)
    else $error("sync_err released while enabled");

  a_sync_quiet: assert property (@(posedge clk) disable iff (reset)
    sync_err |-> !fifo_rd_en && !wr_app_en && !app_wdf_wren)
    else $error("activity during sync_err");

endmodule

bind ddr3_wr_control ddr3_wr_control_props u_ddr3_wr_control_props (.*);

`default_nettype wire

/* testbench/tb_ddr3_wr_control.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ddr3_wr_control import ddr3_wr_pkg::*; ();

  localparam int CREDIT_WIDTH = 5;
  localparam int SYNC_STAGES  = 2;
  localparam int MAX_CYCLES   = 4000;  // about eight fills at half ready rate

  logic        clk = 1'b0;
  logic        reset;
  logic        acq_enabled;
  logic        acq_done;
  logic        checksum_memory_range;
  fifo_word_t  fifo_word = '0;
  logic        fifo_empty = 1'b1;
  logic        fifo_rd_en;
  logic        app_wdf_wren;
  logic        app_wdf_end;
  logic        app_wdf_rdy = 1'b0;
  ddr3_addr_t  wr_addr;
  logic        wr_app_en;
  logic        wr_app_rdy = 1'b0;
  header_rec_t header_wr_dat;
  logic        header_wr_en;
  logic        sync_err;
  logic        wr_done;

  fifo_word_t   fifo_q[$];    // fwft fifo contents, head at index 0
  fifo_word_t   data_exp[$];  // words memory must take, in order
  burst_addr_t  addr_exp[$];  // burst addresses in acceptance order
  header_rec_t  hdr_exp[$];
  burst_addr_t  cur_addr;     // model of the address register
  burst_count_t bursts;       // bursts since acq_enabled rose
  logic [15:0]  lfsr = 16'd55526;
  int           cycles = 0;

  ddr3_wr_control #(
    .CREDIT_WIDTH(CREDIT_WIDTH),
    .SYNC_STAGES (SYNC_STAGES)
  ) u_ddr3_wr_control (.*);

  initial begin
    forever #2 clk = ~clk;  // 4 ns period
  end

  // taps 16,14,13,11
  function logic lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  task automatic fail_plain(input string msg);
    $display("%s at %0t ns", msg, $time);
    $display("TB FAILED");
    $fatal(1, "stopping on error");
  endtask

  task automatic check_value(input string name, input logic [151:0] got,
                             input logic [151:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // random ready, one lfsr step per bit, and the fifo head after any pop
  always @(negedge clk) begin
    app_wdf_rdy <= lfsr_bit();
    wr_app_rdy  <= lfsr_bit();
    fifo_word   <= (fifo_q.size() != 0) ? fifo_q[0] : '0;
    fifo_empty  <= (fifo_q.size() == 0);
  end

  // scoreboard, sees the values from before the edge
  always @(posedge clk) begin
    burst_addr_t a;
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, controller stopped making progress", cycles);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end else if (!reset) begin
      if (app_wdf_wren && app_wdf_rdy) begin
        if (data_exp.size() == 0) fail_plain("data accepted with no word expected");
        check_value("fifo_rd_en", 152'(fifo_rd_en), 152'(1'b1));  // pop with every accept
        check_value("fifo_word", 152'(fifo_word), 152'(data_exp.pop_front()));
      end
      if (fifo_rd_en) begin
        if (fifo_q.size() == 0) fail_plain("FIFO popped while empty");
        void'(fifo_q.pop_front());  // next head shows at the falling edge
      end
      if (wr_app_en && wr_app_rdy) begin
        if (addr_exp.size() == 0) fail_plain("address accepted with none expected");
        a = addr_exp.pop_front();
        check_value("wr_addr", 152'(wr_addr), 152'({a, 3'b000}));
      end
      if (header_wr_en) begin
        if (hdr_exp.size() == 0) fail_plain("header_wr_en pulsed with no header expected");
        check_value("header_wr_dat", 152'(header_wr_dat), 152'(hdr_exp.pop_front()));
      end
    end
  end

  task automatic push_word(input logic [3:0] tag, input payload_t payload);
    fifo_word_t w;
    w.tag     = tag_t'(tag);
    w.payload = payload;
    fifo_q.push_back(w);
    fifo_word  <= fifo_q[0];
    fifo_empty <= 1'b0;
  endtask

  task automatic enable_acq();
    acq_enabled = 1'b1;
    cur_addr    = burst_addr_t'(1);  // start address after enable
    bursts      = '0;
  endtask

  // waveform header with n data bursts behind it
  task automatic send_wfm(input burst_addr_t start, input int n);
    payload_t p;
    p = '0;
    p[WFM_ADDR_LSB +: 23] = start;
    p[13:0] = 14'(n);
    push_word(4'd2, p);
    data_exp.push_back(fifo_q[fifo_q.size()-1]);
    for (int i = 0; i < n; i++) begin
      push_word(4'd0, {32'hda7a0000, 9'd0, start, 64'(i)});
      data_exp.push_back(fifo_q[fifo_q.size()-1]);
    end
    for (int i = 0; i <= n; i++) addr_exp.push_back(start + burst_addr_t'(i));
    cur_addr = start + burst_addr_t'(n + 1);
    bursts   = bursts + burst_count_t'(n + 1);
  endtask

  task automatic send_cksm(input payload_t p);
    burst_addr_t a;
    push_word(4'd4, p);
    data_exp.push_back(fifo_q[fifo_q.size()-1]);
    a = {checksum_memory_range, cur_addr[21:0]};  // buffer bit swapped
    addr_exp.push_back(a);
    cur_addr = a + 1'b1;
    bursts   = bursts + 1'b1;
  endtask

  task automatic send_fill(input logic buf_sel, input payload_t p);
    header_rec_t h;
    p[FILL_BUF_BIT] = buf_sel;
    push_word(4'd1, p);
    data_exp.push_back(fifo_q[fifo_q.size()-1]);
    addr_exp.push_back({buf_sel, 22'd0});
    h.total_bursts = bursts + 1'b1;  // counted before the header's own address
    h.payload      = p;
    hdr_exp.push_back(h);
    cur_addr = {buf_sel, 22'd1};
    bursts   = bursts + 1'b1;
  endtask

  // wait for done, check that it holds, then release it
  task automatic finish_fill();
    int n;
    while (!wr_done) @(negedge clk);
    repeat (4) begin
      @(negedge clk);
      assert (wr_done) else fail_plain("wr_done dropped while acq_done was low");
    end
    acq_done = 1'b1;
    n = 0;
    while (wr_done) begin
      @(negedge clk);
      n++;
    end
    assert (n <= SYNC_STAGES + 2) else fail_plain("wr_done released too late");
    acq_done = 1'b0;
  endtask

  task automatic bad_tag_recovery();
    push_word(4'hb, 128'hbad);
    while (!sync_err) @(negedge clk);
    repeat (10) begin
      @(negedge clk);
      assert (sync_err) else fail_plain("sync_err cleared while acq_enabled was high");
    end
    acq_enabled = 1'b0;
    fifo_q.delete();  // flush the lost word
    fifo_word  <= '0;
    fifo_empty <= 1'b1;
    repeat (3) @(negedge clk);
    assert (!sync_err) else fail_plain("sync_err stuck after acq_enabled dropped");
    enable_acq();
  endtask

  initial begin
    reset                 = 1'b1;
    acq_enabled           = 1'b0;
    acq_done              = 1'b0;
    checksum_memory_range = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    enable_acq();

    checksum_memory_range = 1'b1;
    send_wfm(23'd100, 3);
    send_wfm(23'd200, 0);
    send_cksm(128'hc0ffee01);
    send_fill(1'b0, 128'h1111_0000_0000_0000_0000_0000_0000_0001);
    finish_fill();

    checksum_memory_range = 1'b0;
    send_wfm(23'h400010, 5);
    send_cksm(128'hc0ffee02);
    send_fill(1'b1, 128'h2222_0000_0000_0000_0000_0000_0000_0002);
    finish_fill();

    send_wfm(23'd50, 40);  // long block keeps several bursts in flight
    send_cksm(128'hc0ffee03);
    send_fill(1'b0, 128'h3333_0000_0000_0000_0000_0000_0000_0003);
    finish_fill();

    bad_tag_recovery();
    checksum_memory_range = 1'b1;
    send_cksm(128'hc0ffee04);  // checksum right after enable uses address 1
    send_fill(1'b1, 128'h4444_0000_0000_0000_0000_0000_0000_0004);
    finish_fill();

    repeat (10) @(negedge clk);
    if (data_exp.size() != 0) begin
      fail_plain("words left unwritten");
    end else if (addr_exp.size() != 0) begin
      fail_plain("addresses left unaccepted");
    end else if (hdr_exp.size() != 0) begin
      fail_plain("header records never pushed");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
